/* Makefile */
# Verilator build and run of the fetch stage testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_ifetch -f project.f \
		--Mdir obj_dir -o sim_ifetch
	./obj_dir/sim_ifetch | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* common/fetch_pkg.sv */
// ==============================
// fetch package
// address type, opcodes, instruction word views and reset vector
// shared by the fetch stage and its testbench
// ==============================

package fetch_pkg;

	// ==============================
	// addresses
	// ==============================

	// byte address of an instruction
	typedef logic [31:0] addr_t;

	// every instruction is one 32-bit word
	localparam int unsigned INSN_LEN = 4;

	// first fetch address after reset
	localparam addr_t RESET_PC = 32'h0000_1000;

	// ==============================
	// opcodes
	// ==============================

	localparam logic [6:0] OP_NOP = 7'h00;
	// conditional branch, backward ones are predicted taken
	localparam logic [6:0] OP_BRANCH = 7'h10;
	// links to the next instruction and falls through
	localparam logic [6:0] OP_CALL = 7'h11;
	// returns to the last linked address
	localparam logic [6:0] OP_RET = 7'h12;
	localparam logic [6:0] OP_ALU = 7'h20;

	// ==============================
	// instruction word
	// ==============================

	// generic view, opcode and the rest of the word
	typedef struct packed {
		logic [6:0] opcode;
		logic [24:0] payload;
	} any_fmt_t;

	// branch view
	// disp counts instructions and is signed
	typedef struct packed {
		logic [6:0] opcode;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [2:0] cond;
		logic signed [11:0] disp;
	} br_fmt_t;

	// one word, decoded either way
	typedef union packed {
		any_fmt_t any;
		br_fmt_t br;
	} instr_u;

	// word shown on a slot that holds nothing
	localparam instr_u NOP_INSN = instr_u'({OP_NOP, 25'd0});

endpackage

/* ifetch/fetch_buffer.sv */
// ==============================
// fetch buffer
// two banks of two slots, head bank steered to the slots
// loads cache pairs, hands instructions to the issue queue
// ==============================

`timescale 1ns/10ps

module fetch_buffer (
	input logic clk,
	input logic rst,
	input logic hit,
	input fetch_pkg::instr_u inst0,
	input fetch_pkg::instr_u inst1,
	input fetch_pkg::addr_t pc_i,
	input logic iq_free0,
	input logic iq_free1,
	input logic redirect,
	input logic kill_slot1,
	input logic branchmiss,
	output logic fetch_go,
	output logic head_steered,
	output logic slot0_v,
	output fetch_pkg::instr_u slot0_instr,
	output fetch_pkg::addr_t slot0_pc,
	output logic slot1_v,
	output fetch_pkg::instr_u slot1_instr,
	output fetch_pkg::addr_t slot1_pc
);

	// bank currently feeding the slots
	logic head;
	// valid bits per bank, bit 0 is the older slot
	logic [1:0] bank_v [2];
	// bank has already redirected the pc
	logic [1:0] steered;
	// payload per bank and slot
	fetch_pkg::instr_u buf_instr [2][2];
	fetch_pkg::addr_t buf_pc [2][2];

	logic take0;
	logic take1;
	logic slot1_kill;
	logic keep0;
	logic keep1;
	logic head_empty;
	logic other_empty;
	logic load_bank;
	logic head_done;

	// ==============================
	// head bank onto the slots
	// ==============================

	assign slot0_v = bank_v[head][0];
	assign slot1_v = bank_v[head][1];
	// empty slots read as nop
	assign slot0_instr = slot0_v ? buf_instr[head][0] : fetch_pkg::NOP_INSN;
	assign slot1_instr = slot1_v ? buf_instr[head][1] : fetch_pkg::NOP_INSN;
	assign slot0_pc = buf_pc[head][0];
	assign slot1_pc = buf_pc[head][1];
	assign head_steered = steered[head];

	// ==============================
	// enqueue and fetch decisions
	// ==============================

	always_comb begin
		// slot after a redirecting slot0 is dropped, never handed over
		slot1_kill = redirect & kill_slot1;
		take0 = slot0_v & iq_free0;
		// slot1 only goes behind slot0 or alone in the first queue slot
		take1 = slot1_v & ~slot1_kill & ((take0 & iq_free1) | (~slot0_v & iq_free0));
		keep0 = slot0_v & ~take0;
		keep1 = slot1_v & ~take1 & ~slot1_kill;
		head_empty = (bank_v[head] == 2'b00);
		other_empty = (bank_v[~head] == 2'b00);
		// refill the head bank first when it is empty
		load_bank = head_empty ? head : ~head;
		fetch_go = hit & (head_empty | other_empty) & ~branchmiss & ~redirect;
		// head drained and not being refilled, steer to the other bank
		head_done = ~keep0 & ~keep1 & ~(fetch_go & (load_bank == head));
	end

	// ==============================
	// control state
	// ==============================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			head <= 1'b0;
			bank_v[0] <= 2'b00;
			bank_v[1] <= 2'b00;
			steered <= 2'b00;
		end else if (branchmiss) begin
			// flush everything and restart on bank 0
			head <= 1'b0;
			bank_v[0] <= 2'b00;
			bank_v[1] <= 2'b00;
			steered <= 2'b00;
		end else begin
			bank_v[head] <= {keep1, keep0};
			// younger pair fetched past the flow change
			if (redirect) begin
				bank_v[~head] <= 2'b00;
				steered[head] <= 1'b1;
			end
			// new pair, fresh for predecode
			if (fetch_go) begin
				bank_v[load_bank] <= 2'b11;
				steered[load_bank] <= 1'b0;
			end
			if (head_done)
				head <= ~head;
		end
	end

	// ==============================
	// payload
	// ==============================

	always_ff @(posedge clk) begin
		if (fetch_go) begin
			buf_instr[load_bank][0] <= inst0;
			buf_instr[load_bank][1] <= inst1;
			buf_pc[load_bank][0] <= pc_i;
			buf_pc[load_bank][1] <= pc_i + fetch_pkg::INSN_LEN;
		end
	end

endmodule

/* ifetch/fetch_pc.sv */
// ==============================
// fetch program counter
// steps a pair at a time, takes predecode redirects
// and branch miss restarts
// ==============================

`timescale 1ns/10ps

module fetch_pc (
	input logic clk,
	input logic rst,
	input logic fetch_go,
	input logic redirect,
	input fetch_pkg::addr_t redirect_pc,
	input logic branchmiss,
	input fetch_pkg::addr_t misspc,
	output fetch_pkg::addr_t pc
);

	// ==============================
	// next address
	// ==============================

	// two instructions per accepted pair
	localparam fetch_pkg::addr_t PAIR_STEP = 2 * fetch_pkg::INSN_LEN;

	fetch_pkg::addr_t pc_next;

	always_comb begin
		// hold when nothing was accepted
		pc_next = pc;
		// branch miss from the core wins over any prediction
		if (branchmiss)
			pc_next = misspc;
		// predicted backward branch or return
		else if (redirect)
			pc_next = redirect_pc;
		// pair went into a buffer bank
		else if (fetch_go)
			pc_next = pc + PAIR_STEP;
	end

	// ==============================
	// pc register
	// ==============================

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			pc <= fetch_pkg::RESET_PC;
		else
			pc <= pc_next;
	end

endmodule

/* ifetch/ifetch_top.sv */
// ==============================
// instruction fetch top level
// pc, double-banked fetch buffer, branch predecode and
// return stack of the dual-issue fetch stage
// ==============================

`timescale 1ns/10ps

module ifetch_top #(
	parameter int RSB_DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input logic hit,
	input fetch_pkg::instr_u inst0,
	input fetch_pkg::instr_u inst1,
	input fetch_pkg::addr_t pc_i,
	input logic iq_free0,
	input logic iq_free1,
	input logic branchmiss,
	input fetch_pkg::addr_t misspc,
	output fetch_pkg::addr_t pc,
	output logic slot0_v,
	output fetch_pkg::instr_u slot0_instr,
	output fetch_pkg::addr_t slot0_pc,
	output logic slot1_v,
	output fetch_pkg::instr_u slot1_instr,
	output fetch_pkg::addr_t slot1_pc
);

	// buffer to pc
	logic fetch_go;
	logic head_steered;

	// predecode to pc and buffer
	logic redirect;
	fetch_pkg::addr_t redirect_pc;
	logic kill_slot1;

	// predecode to and from the return stack
	logic push;
	logic pop;
	fetch_pkg::addr_t push_pc;
	fetch_pkg::addr_t ret_pc;

	fetch_pc fetch_pc_i (
		.clk(clk),
		.rst(rst),
		.fetch_go(fetch_go),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.branchmiss(branchmiss),
		.misspc(misspc),
		.pc(pc)
	);

	fetch_buffer fetch_buffer_i (
		.clk(clk),
		.rst(rst),
		.hit(hit),
		.inst0(inst0),
		.inst1(inst1),
		.pc_i(pc_i),
		.iq_free0(iq_free0),
		.iq_free1(iq_free1),
		.redirect(redirect),
		.kill_slot1(kill_slot1),
		.branchmiss(branchmiss),
		.fetch_go(fetch_go),
		.head_steered(head_steered),
		.slot0_v(slot0_v),
		.slot0_instr(slot0_instr),
		.slot0_pc(slot0_pc),
		.slot1_v(slot1_v),
		.slot1_instr(slot1_instr),
		.slot1_pc(slot1_pc)
	);

	branch_predecode branch_predecode_i (
		.slot0_v(slot0_v),
		.slot0_instr(slot0_instr),
		.slot0_pc(slot0_pc),
		.slot1_v(slot1_v),
		.slot1_instr(slot1_instr),
		.slot1_pc(slot1_pc),
		.head_steered(head_steered),
		.iq_free0(iq_free0),
		.iq_free1(iq_free1),
		.ret_pc(ret_pc),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.kill_slot1(kill_slot1),
		.push(push),
		.pop(pop),
		.push_pc(push_pc)
	);

	return_stack #(
		.DEPTH(RSB_DEPTH)
	) return_stack_i (
		.clk(clk),
		.rst(rst),
		.push(push),
		.pop(pop),
		.push_pc(push_pc),
		.ret_pc(ret_pc)
	);

endmodule

/* logic/branch_predecode.sv */
// ==============================
// branch predecode
// finds the first flow change in the head pair, predicts its
// target and drives the return stack for calls and returns
// ==============================

`timescale 1ns/10ps

module branch_predecode (
	input logic slot0_v,
	input fetch_pkg::instr_u slot0_instr,
	input fetch_pkg::addr_t slot0_pc,
	input logic slot1_v,
	input fetch_pkg::instr_u slot1_instr,
	input fetch_pkg::addr_t slot1_pc,
	input logic head_steered,
	input logic iq_free0,
	input logic iq_free1,
	input fetch_pkg::addr_t ret_pc,
	output logic redirect,
	output fetch_pkg::addr_t redirect_pc,
	output logic kill_slot1,
	output logic push,
	output logic pop,
	output fetch_pkg::addr_t push_pc
);

	logic bb0, bb1;
	logic ret0, ret1;
	logic call0, call1;
	logic take0, take1;
	fetch_pkg::addr_t tgt0, tgt1;

	// ==============================
	// decode
	// ==============================

	// backward branch means opcode match and negative disp
	assign bb0 = slot0_v & (slot0_instr.br.opcode == fetch_pkg::OP_BRANCH) & slot0_instr.br.disp[11];
	assign bb1 = slot1_v & (slot1_instr.br.opcode == fetch_pkg::OP_BRANCH) & slot1_instr.br.disp[11];
	assign ret0 = slot0_v & (slot0_instr.any.opcode == fetch_pkg::OP_RET);
	assign ret1 = slot1_v & (slot1_instr.any.opcode == fetch_pkg::OP_RET);
	assign call0 = slot0_v & (slot0_instr.any.opcode == fetch_pkg::OP_CALL);
	assign call1 = slot1_v & (slot1_instr.any.opcode == fetch_pkg::OP_CALL);

	// branch targets, disp sign extended and scaled to bytes
	assign tgt0 = slot0_pc + {{18{slot0_instr.br.disp[11]}}, slot0_instr.br.disp, 2'b00};
	assign tgt1 = slot1_pc + {{18{slot1_instr.br.disp[11]}}, slot1_instr.br.disp, 2'b00};

	// ==============================
	// redirect
	// ==============================

	always_comb begin
		// a bank redirects once, on its first cycle at the head
		redirect = ~head_steered & (bb0 | ret0 | bb1 | ret1);
		kill_slot1 = ~head_steered & (bb0 | ret0);
		if (bb0)
			redirect_pc = tgt0;
		else if (ret0)
			redirect_pc = ret_pc;
		else if (bb1)
			redirect_pc = tgt1;
		// call in slot0 has not been pushed yet, so bypass its link
		else if (call0)
			redirect_pc = slot0_pc + fetch_pkg::INSN_LEN;
		else
			redirect_pc = ret_pc;
	end

	// ==============================
	// return stack update at hand-off
	// ==============================

	always_comb begin
		// same enqueue rule as the buffer
		take0 = slot0_v & iq_free0;
		take1 = slot1_v & ~kill_slot1 & ((take0 & iq_free1) | (~slot0_v & iq_free0));
		push = (take0 & call0) | (take1 & call1);
		pop = (take0 & ret0) | (take1 & ret1);
		// two calls in one pair only keep the younger link
		if (take1 & call1)
			push_pc = slot1_pc + fetch_pkg::INSN_LEN;
		else
			push_pc = slot0_pc + fetch_pkg::INSN_LEN;
	end

endmodule

/* logic/return_stack.sv */
// ==============================
// return stack buffer
// circular stack of link addresses that loses the oldest on overflow
// ==============================

`timescale 1ns/10ps

module return_stack #(
	parameter int DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input logic push,
	input logic pop,
	input fetch_pkg::addr_t push_pc,
	output fetch_pkg::addr_t ret_pc
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	fetch_pkg::addr_t stack [DEPTH];
	// index of the top entry
	logic [PTR_W-1:0] ptr;
	// live entries saturating at DEPTH
	logic [CNT_W-1:0] count;
	logic [PTR_W-1:0] ptr_up;
	logic [PTR_W-1:0] ptr_dn;

	// pointer wraps in both directions
	assign ptr_up = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	assign ptr_dn = (ptr == '0) ? PTR_W'(DEPTH - 1) : ptr - 1'b1;

	// empty stack predicts the reset address
	assign ret_pc = (count == '0) ? fetch_pkg::RESET_PC : stack[ptr];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
			count <= '0;
		end else if (push & ~pop) begin
			ptr <= ptr_up;
			if (count != CNT_W'(DEPTH))
				count <= count + 1'b1;
		end else if (pop & ~push & (count != '0)) begin
			ptr <= ptr_dn;
			count <= count - 1'b1;
		end
		// push and pop together leave the stack as it was
	end

	// new link goes one above the current top
	always_ff @(posedge clk) begin
		if (push & ~pop)
			stack[ptr_up] <= push_pc;
	end

endmodule

/* project.f */
common/fetch_pkg.sv
logic/return_stack.sv
logic/branch_predecode.sv
ifetch/fetch_pc.sv
ifetch/fetch_buffer.sv
ifetch/ifetch_top.sv
testbench/fetch_checker.sv
testbench/tb_ifetch.sv

/* testbench/fetch_checker.sv */
// ==============================
// fetch checker
// reference model of the architectural instruction stream
// that compares every instruction handed to the issue queue
// ==============================

`timescale 1ns/10ps

module fetch_checker #(
	parameter int PROG_WORDS = 128,
	parameter int RSB_DEPTH = 8
) (
	input logic clk,
	input logic rst,
	input logic slot0_v,
	input fetch_pkg::instr_u slot0_instr,
	input fetch_pkg::addr_t slot0_pc,
	input logic slot1_v,
	input fetch_pkg::instr_u slot1_instr,
	input fetch_pkg::addr_t slot1_pc,
	input logic iq_free0,
	input logic iq_free1,
	input logic branchmiss,
	input fetch_pkg::addr_t misspc,
	input fetch_pkg::addr_t pc,
	input fetch_pkg::instr_u prog [PROG_WORDS],
	input fetch_pkg::addr_t watch_pc,
	output int watch_hits,
	output int handed,
	output int errors
);

	// next instruction the program should hand over
	fetch_pkg::addr_t exp_pc;
	// model of the link stack with the newest at the back
	fetch_pkg::addr_t link_stack [$];
	// fetch address due one cycle after reset or a branch miss
	logic pc_due;
	fetch_pkg::addr_t pc_want;
	int err_cnt = 0;
	logic take0;
	logic take1;
	logic kill1;

	assign errors = err_cnt;

	function automatic logic backward_branch(input fetch_pkg::instr_u w);
		return (w.any.opcode == fetch_pkg::OP_BRANCH) && ($signed(w.br.disp) < 0);
	endfunction

	function automatic logic is_return(input fetch_pkg::instr_u w);
		return w.any.opcode == fetch_pkg::OP_RET;
	endfunction

	// empty stack predicts the reset address
	function automatic fetch_pkg::addr_t stack_top();
		if (link_stack.size() == 0)
			return fetch_pkg::RESET_PC;
		return link_stack[$];
	endfunction

	// reference model of the next architectural pc after w
	function automatic fetch_pkg::addr_t next_pc(input fetch_pkg::addr_t cur_pc,
		input fetch_pkg::instr_u w, input fetch_pkg::addr_t top);
		int disp;
		disp = int'($signed(w.br.disp));
		if (backward_branch(w))
			return cur_pc + fetch_pkg::addr_t'(disp * int'(fetch_pkg::INSN_LEN));
		if (is_return(w))
			return top;
		// calls link and fall through like the rest
		return cur_pc + fetch_pkg::INSN_LEN;
	endfunction

	function automatic fetch_pkg::instr_u word_at(input fetch_pkg::addr_t a);
		int idx;
		idx = int'((a - fetch_pkg::RESET_PC) >> 2);
		if (idx < 0 || idx >= PROG_WORDS)
			return fetch_pkg::NOP_INSN;
		return prog[idx];
	endfunction

	task automatic flag_error(input string msg);
		$display("[ERROR] t=%0t %s", $time, msg);
		err_cnt++;
	endtask

	// one instruction leaves a slot for the issue queue
	task automatic hand_over(input int slot, input fetch_pkg::addr_t slot_pc,
		input fetch_pkg::instr_u w);
		fetch_pkg::instr_u want;
		fetch_pkg::addr_t top;
		want = word_at(exp_pc);
		top = stack_top();
		if (slot_pc !== exp_pc)
			flag_error($sformatf("slot%0d pc %h, expected %h", slot, slot_pc, exp_pc));
		else if (w !== want)
			flag_error($sformatf("slot%0d word %h at pc %h, expected %h",
				slot, w, slot_pc, want));
		if (exp_pc == watch_pc)
			watch_hits++;
		handed++;
		// stack follows the expected stream and loses the oldest link on overflow
		if (want.any.opcode == fetch_pkg::OP_CALL) begin
			link_stack.push_back(exp_pc + fetch_pkg::INSN_LEN);
			if (link_stack.size() > RSB_DEPTH)
				link_stack.delete(0);
		end else if (is_return(want) && link_stack.size() != 0) begin
			link_stack.delete(link_stack.size() - 1);
		end
		exp_pc = next_pc(exp_pc, want, top);
	endtask

	// ==============================
	// comparing process
	// ==============================

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			exp_pc = fetch_pkg::RESET_PC;
			link_stack.delete();
			watch_hits = 0;
			handed = 0;
			pc_due = 1'b1;
			pc_want = fetch_pkg::RESET_PC;
			if (slot0_v === 1'b1 || slot1_v === 1'b1)
				flag_error("slot valid during reset");
		end else if (branchmiss) begin
			// core restart drops the buffered instructions
			exp_pc = misspc;
			pc_due = 1'b1;
			pc_want = misspc;
		end else begin
			if (pc_due && pc !== pc_want)
				flag_error($sformatf("fetch pc %h after restart, expected %h", pc, pc_want));
			pc_due = 1'b0;
			take0 = slot0_v && iq_free0;
			// a predicted flow change in slot0 drops slot1
			kill1 = slot0_v && (backward_branch(slot0_instr) || is_return(slot0_instr));
			take1 = slot1_v && !kill1 && ((take0 && iq_free1) || (!slot0_v && iq_free0));
			if (take0)
				hand_over(0, slot0_pc, slot0_instr);
			if (take1)
				hand_over(1, slot1_pc, slot1_instr);
		end
	end

endmodule

/* testbench/tb_ifetch.sv */
// ==============================
// fetch stage testbench
// clock, reset, program memory model, random cache hits
// and queue space, branch miss injection and watchdog
// ==============================

`timescale 1ns/10ps

module tb_ifetch;

	localparam int RSB_DEPTH = 8;
	localparam int PROG_WORDS = 128;
	// program landmarks as word indices from the reset address
	localparam int LOOP_BR = 24;
	localparam int CALL_BASE = 30;
	localparam int RET_IDX = CALL_BASE + 2 * RSB_DEPTH;
	localparam int SEQ_BASE = 50;
	localparam int LATE_BASE = 70;
	localparam int LOOP2_BR = 83;
	localparam int LAST_IDX = 110;
	// instructions handed over by all phases with headroom
	localparam int TEST_INSNS = 500;
	// worst cycles per instruction under random hits and stalls
	localparam int STALL_RATIO = 8;
	localparam int WATCHDOG_CYCLES = TEST_INSNS * STALL_RATIO;

	logic clk;
	logic rst;
	logic hit;
	fetch_pkg::instr_u inst0;
	fetch_pkg::instr_u inst1;
	fetch_pkg::addr_t pc_i;
	logic iq_free0;
	logic iq_free1;
	logic branchmiss;
	fetch_pkg::addr_t misspc;
	fetch_pkg::addr_t pc;
	logic slot0_v;
	fetch_pkg::instr_u slot0_instr;
	fetch_pkg::addr_t slot0_pc;
	logic slot1_v;
	fetch_pkg::instr_u slot1_instr;
	fetch_pkg::addr_t slot1_pc;

	fetch_pkg::instr_u prog [PROG_WORDS];
	fetch_pkg::addr_t watch_pc;
	int watch_hits;
	int handed;
	int errors;
	int seed;

	ifetch_top #(
		.RSB_DEPTH(RSB_DEPTH)
	) ifetch_top_i (
		.clk(clk),
		.rst(rst),
		.hit(hit),
		.inst0(inst0),
		.inst1(inst1),
		.pc_i(pc_i),
		.iq_free0(iq_free0),
		.iq_free1(iq_free1),
		.branchmiss(branchmiss),
		.misspc(misspc),
		.pc(pc),
		.slot0_v(slot0_v),
		.slot0_instr(slot0_instr),
		.slot0_pc(slot0_pc),
		.slot1_v(slot1_v),
		.slot1_instr(slot1_instr),
		.slot1_pc(slot1_pc)
	);

	fetch_checker #(
		.PROG_WORDS(PROG_WORDS),
		.RSB_DEPTH(RSB_DEPTH)
	) fetch_checker_i (
		.clk(clk),
		.rst(rst),
		.slot0_v(slot0_v),
		.slot0_instr(slot0_instr),
		.slot0_pc(slot0_pc),
		.slot1_v(slot1_v),
		.slot1_instr(slot1_instr),
		.slot1_pc(slot1_pc),
		.iq_free0(iq_free0),
		.iq_free1(iq_free1),
		.branchmiss(branchmiss),
		.misspc(misspc),
		.pc(pc),
		.prog(prog),
		.watch_pc(watch_pc),
		.watch_hits(watch_hits),
		.handed(handed),
		.errors(errors)
	);

	// ==============================
	// program memory
	// ==============================

	function automatic fetch_pkg::addr_t addr_of(input int idx);
		return fetch_pkg::RESET_PC + fetch_pkg::addr_t'(idx) * fetch_pkg::INSN_LEN;
	endfunction

	// alu word that differs at every address
	function automatic fetch_pkg::instr_u fill_word(input fetch_pkg::addr_t a);
		return fetch_pkg::instr_u'({fetch_pkg::OP_ALU, 25'((a >> 2) ^ (a >> 27))});
	endfunction

	function automatic fetch_pkg::instr_u plain_word(input logic [6:0] op);
		return fetch_pkg::instr_u'({op, 25'd0});
	endfunction

	function automatic fetch_pkg::instr_u branch_word(input int disp);
		fetch_pkg::instr_u w;
		w = fetch_pkg::NOP_INSN;
		w.br.opcode = fetch_pkg::OP_BRANCH;
		w.br.disp = 12'(disp);
		return w;
	endfunction

	// outside the program the fill pattern continues
	function automatic fetch_pkg::instr_u mem_word(input fetch_pkg::addr_t a);
		int idx;
		idx = int'((a - fetch_pkg::RESET_PC) >> 2);
		if (idx < 0 || idx >= PROG_WORDS)
			return fill_word(a);
		return prog[idx];
	endfunction

	task automatic load_program();
		int i;
		for (i = 0; i < PROG_WORDS; i++)
			prog[i] = fill_word(addr_of(i));
		// four-instruction body with the branch in slot0
		prog[LOOP_BR] = branch_word(-4);
		// nested calls spaced so no pair holds two of them
		for (i = 0; i < RSB_DEPTH; i++)
			prog[CALL_BASE + 2 * i] = plain_word(fetch_pkg::OP_CALL);
		prog[RET_IDX] = plain_word(fetch_pkg::OP_RET);
		// three-instruction body with the branch in slot1
		prog[LOOP2_BR] = branch_word(-3);
	endtask

	// ==============================
	// stimulus on the falling edge
	// ==============================

	task automatic drive_random();
		hit = (($random(seed) & 3) != 0);
		pc_i = pc;
		inst0 = mem_word(pc);
		inst1 = mem_word(pc + fetch_pkg::INSN_LEN);
		iq_free0 = (($random(seed) % 3) != 0);
		// second queue slot only with the first
		iq_free1 = iq_free0 && (($random(seed) & 1) != 0);
	endtask

	// run until the instruction at idx was handed over n more times
	task automatic run_until_hits(input int idx, input int n);
		int base;
		watch_pc = addr_of(idx);
		base = watch_hits;
		while (watch_hits < base + n) begin
			drive_random();
			@(negedge clk);
		end
	endtask

	task automatic raise_branchmiss(input int idx);
		branchmiss = 1'b1;
		misspc = addr_of(idx);
		// nothing handed over during the redirect cycle
		hit = 1'b0;
		iq_free0 = 1'b0;
		iq_free1 = 1'b0;
		@(negedge clk);
		branchmiss = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		seed = 20184;
		rst = 1'b1;
		hit = 1'b0;
		inst0 = fetch_pkg::NOP_INSN;
		inst1 = fetch_pkg::NOP_INSN;
		pc_i = '0;
		iq_free0 = 1'b0;
		iq_free1 = 1'b0;
		branchmiss = 1'b0;
		misspc = '0;
		watch_pc = fetch_pkg::RESET_PC;
		load_program();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// sequential code into the first loop and out after three passes
		run_until_hits(LOOP_BR, 3);
		raise_branchmiss(LOOP_BR + 1);
		// nested calls to full stack depth and then ten returns
		run_until_hits(RET_IDX, 10);
		raise_branchmiss(SEQ_BASE);
		// miss in straight code drops the buffered pairs
		run_until_hits(SEQ_BASE + 3, 1);
		raise_branchmiss(LATE_BASE);
		run_until_hits(LOOP2_BR, 3);
		raise_branchmiss(LOOP2_BR + 1);
		run_until_hits(LAST_IDX, 1);

		$display("errors: %0d, instructions checked: %0d", errors, handed);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// ==============================
	// watchdog
	// ==============================

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("run timed out after %0d cycles, the test program did not finish",
			WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule
